// ==== verilog/tsp_defines.svh ====
`ifndef TSP_DEFINES_SVH
`define TSP_DEFINES_SVH

// packet geometry
`define TSP_PACK_BYTES 188
`define TSP_PACK_WORDS 47

`define TSP_FILTER_NUM 4

// bus widths
`define TSP_REG_ADDR_BITS 8
`define TSP_RAM_ADDR_BITS 8 // filter n owns words n*47 .. n*47+46

// host register map
`define TSP_ADDR_INDEX 0
`define TSP_ADDR_PID 1 // enable in bit 16, pid in 12:0
`define TSP_ADDR_READ_REQUEST 2 // write arms, read returns ready
`define TSP_ADDR_TS_DATA_BASE 128 // word 0 of selected buffer

`endif

// ==== verilog/tsp_pkg.sv ====
package tsp_pkg;

	// one PID filter as seen by the capture engine
	typedef struct packed {
		logic [12:0] pid;
		logic        enable;
		logic        armed; // capture the next matching packet
	} filter_cfg_t;

	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_HEADER, // bytes 0..2, pid not known yet
		CAP_STORE,
		CAP_SKIP
	} capture_state_t;

	typedef enum logic {
		HOST_IDLE,
		HOST_RAM_WAIT
	} host_state_t;

endpackage

// ==== verilog/ts_mem_if.sv ====
`timescale 1ns/1ps
`include "tsp_defines.svh"

interface ts_mem_if;
	logic                          req;
	logic                          we;
	logic [`TSP_RAM_ADDR_BITS-1:0] addr;
	logic [31:0]                   wdata;
	logic                          gnt;
	logic [31:0]                   rdata; // valid the cycle after gnt

	// fields held steady until gnt
	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

// ==== verilog/tsp_host_regs.sv ====
`timescale 1ns/1ps
`include "tsp_defines.svh"

module tsp_host_regs (
	input  logic                          mpeg_clk,
	input  logic                          rst_n,
	input  logic                          wen,
	input  logic                          ren,
	input  logic [`TSP_REG_ADDR_BITS-1:0] waddr,
	input  logic [`TSP_REG_ADDR_BITS-1:0] raddr,
	input  logic [31:0]                   wdata,
	output logic [31:0]                   rdata,
	output logic                          rvalid,
	input  logic                          capture_done,
	input  logic [1:0]                    capture_index,
	output tsp_pkg::filter_cfg_t          filter_cfg [`TSP_FILTER_NUM],
	ts_mem_if.requester                   host_mem
);
	import tsp_pkg::*;

	host_state_t                   state;
	logic [1:0]                    sel_idx;
	logic [`TSP_FILTER_NUM-1:0]    ready;
	logic                          rd_granted; // ram word arrives next cycle
	logic                          data_hit;
	logic [`TSP_REG_ADDR_BITS-1:0] word_ofs;
	logic [`TSP_RAM_ADDR_BITS-1:0] sel_base;

	assign word_ofs = raddr - `TSP_REG_ADDR_BITS'(`TSP_ADDR_TS_DATA_BASE);
	assign data_hit = (raddr >= `TSP_REG_ADDR_BITS'(`TSP_ADDR_TS_DATA_BASE)) &&
		(word_ofs < `TSP_REG_ADDR_BITS'(`TSP_PACK_WORDS));
	assign sel_base = `TSP_RAM_ADDR_BITS'(sel_idx * `TSP_PACK_WORDS);

	assign host_mem.we = 1'b0; // read only port
	assign host_mem.wdata = '0;

	// filter table and ready flags
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			sel_idx <= '0;
			ready <= '0;
			for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
				filter_cfg[i] <= '0;
			end
		end else begin
			if (capture_done) begin
				ready[capture_index] <= 1'b1;
				filter_cfg[capture_index].armed <= 1'b0;
			end
			if (wen) begin // host write wins over a same-cycle capture
				case (waddr)
					`TSP_ADDR_INDEX: sel_idx <= wdata[1:0];
					`TSP_ADDR_PID: begin
						filter_cfg[sel_idx].pid <= wdata[12:0];
						filter_cfg[sel_idx].enable <= wdata[16];
					end
					`TSP_ADDR_READ_REQUEST: begin
						filter_cfg[sel_idx].armed <= 1'b1;
						ready[sel_idx] <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	// read sequencing
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			state <= HOST_IDLE;
			rdata <= '0;
			rvalid <= 1'b0;
			rd_granted <= 1'b0;
			host_mem.req <= 1'b0;
		end else begin
			rvalid <= 1'b0;
			case (state)
				HOST_IDLE: begin
					if (ren && data_hit) begin
						host_mem.req <= 1'b1;
						state <= HOST_RAM_WAIT;
					end else if (ren) begin
						rvalid <= 1'b1;
						case (raddr)
							`TSP_ADDR_INDEX: rdata <= {30'd0, sel_idx};
							`TSP_ADDR_PID: rdata <= {15'd0, filter_cfg[sel_idx].enable, 3'd0,
								filter_cfg[sel_idx].pid};
							`TSP_ADDR_READ_REQUEST: rdata <= {31'd0, ready[sel_idx]};
							default: rdata <= '0;
						endcase
					end
				end
				HOST_RAM_WAIT: begin
					if (rd_granted) begin
						rdata <= host_mem.rdata;
						rvalid <= 1'b1;
						rd_granted <= 1'b0;
						state <= HOST_IDLE;
					end else if (host_mem.req && host_mem.gnt) begin
						host_mem.req <= 1'b0;
						rd_granted <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (state == HOST_IDLE && ren && data_hit)
			host_mem.addr <= sel_base + `TSP_RAM_ADDR_BITS'(word_ofs);
	end

endmodule

// ==== verilog/tsp_pid_capture.sv ====
`timescale 1ns/1ps
`include "tsp_defines.svh"

module tsp_pid_capture (
	input  logic                 mpeg_clk,
	input  logic                 rst_n,
	input  logic [7:0]           mpeg_data,
	input  logic                 mpeg_valid,
	input  logic                 mpeg_sync,
	input  tsp_pkg::filter_cfg_t filter_cfg [`TSP_FILTER_NUM],
	ts_mem_if.requester          cap_mem,
	output logic                 capture_done,
	output logic [1:0]           capture_index
);
	import tsp_pkg::*;

	capture_state_t                state;
	logic [7:0]                    byte_cnt; // index of the incoming byte
	logic [5:0]                    word_cnt;
	logic [23:0]                   word_buf; // lanes 0..2 of current word
	logic [1:0]                    cap_idx;
	logic [`TSP_RAM_ADDR_BITS-1:0] cap_base;
	logic                          wr_last;
	logic [12:0]                   pid_now;
	logic                          hit;
	logic [1:0]                    hit_idx;
	logic                          body_byte;
	logic                          decide;
	logic                          store_word;
	logic                          last_granted;

	assign body_byte = mpeg_valid && !mpeg_sync;
	assign decide = body_byte && state == CAP_HEADER && byte_cnt == 8'd2;
	assign store_word = body_byte && state == CAP_STORE && byte_cnt[1:0] == 2'd3;
	assign last_granted = cap_mem.req && cap_mem.gnt && wr_last;

	assign pid_now = {word_buf[12:8], mpeg_data}; // byte1[4:0], byte2
	assign cap_mem.we = 1'b1;

	// lowest numbered filter wins
	always_comb begin
		hit = 1'b0;
		hit_idx = 2'd0;
		for (int i = `TSP_FILTER_NUM - 1; i >= 0; i--) begin
			if (filter_cfg[i].enable && filter_cfg[i].armed &&
				filter_cfg[i].pid == pid_now) begin
				hit = 1'b1;
				hit_idx = 2'(i);
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			state <= CAP_IDLE;
			byte_cnt <= '0;
			word_cnt <= '0;
			wr_last <= 1'b0;
			cap_mem.req <= 1'b0;
			capture_done <= 1'b0;
		end else begin
			capture_done <= last_granted;
			if (cap_mem.req && cap_mem.gnt)
				cap_mem.req <= 1'b0;
			if (mpeg_valid && mpeg_sync) begin // restart on byte 0
				state <= CAP_HEADER;
				byte_cnt <= 8'd1;
				word_cnt <= '0;
			end else if (mpeg_valid) begin
				byte_cnt <= byte_cnt + 8'd1;
				case (state)
					CAP_HEADER: begin
						if (byte_cnt == 8'd2)
							state <= hit ? CAP_STORE : CAP_SKIP;
					end
					CAP_STORE: begin
						if (byte_cnt[1:0] == 2'd3) begin
							cap_mem.req <= 1'b1;
							wr_last <= (word_cnt == 6'(`TSP_PACK_WORDS - 1));
							word_cnt <= word_cnt + 6'd1;
						end
						if (byte_cnt == 8'(`TSP_PACK_BYTES - 1))
							state <= CAP_IDLE;
					end
					default: ;
				endcase
			end
		end
	end

	// packing and write fields
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid && mpeg_sync)
			word_buf[7:0] <= mpeg_data;
		else if (body_byte && byte_cnt[1:0] != 2'd3)
			word_buf[{byte_cnt[1:0], 3'b000} +: 8] <= mpeg_data;
		if (decide) begin
			cap_idx <= hit_idx;
			cap_base <= `TSP_RAM_ADDR_BITS'(hit_idx * `TSP_PACK_WORDS);
		end
		if (store_word) begin
			cap_mem.wdata <= {mpeg_data, word_buf}; // byte 0 in low lane
			cap_mem.addr <= cap_base + `TSP_RAM_ADDR_BITS'(word_cnt);
		end
		if (last_granted)
			capture_index <= cap_idx;
	end

endmodule

// ==== verilog/tsp_mem_arbiter.sv ====
`timescale 1ns/1ps

module tsp_mem_arbiter (
	input  logic        mpeg_clk,
	input  logic        rst_n,
	ts_mem_if.arbiter   cap_mem,
	ts_mem_if.arbiter   host_mem,
	ts_mem_if.requester ram
);

	logic cap_sel;
	logic rd_owner_cap; // last granted read came from capture port

	assign cap_sel = cap_mem.req; // capture always wins

	assign ram.req = cap_mem.req | host_mem.req;
	assign ram.we = cap_sel ? cap_mem.we : host_mem.we;
	assign ram.addr = cap_sel ? cap_mem.addr : host_mem.addr;
	assign ram.wdata = cap_sel ? cap_mem.wdata : host_mem.wdata;

	assign cap_mem.gnt = cap_mem.req & ram.gnt;
	assign host_mem.gnt = !cap_mem.req & host_mem.req & ram.gnt;

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n)
			rd_owner_cap <= 1'b0;
		else if (ram.req && ram.gnt && !ram.we)
			rd_owner_cap <= cap_sel;
	end

	// route the returned word to its owner
	assign cap_mem.rdata = rd_owner_cap ? ram.rdata : '0;
	assign host_mem.rdata = rd_owner_cap ? '0 : ram.rdata;

endmodule

// ==== verilog/tsp_packet_ram.sv ====
`timescale 1ns/1ps
`include "tsp_defines.svh"

module tsp_packet_ram (
	input logic       mpeg_clk,
	ts_mem_if.arbiter mem
);

	// one packet buffer per filter
	logic [31:0] ram_words [0:`TSP_FILTER_NUM*`TSP_PACK_WORDS-1];

	assign mem.gnt = mem.req; // single port, never busy

	always_ff @(posedge mpeg_clk) begin
		if (mem.req && mem.we)
			ram_words[mem.addr] <= mem.wdata;
	end

	always_ff @(posedge mpeg_clk) begin
		if (mem.req && !mem.we)
			mem.rdata <= ram_words[mem.addr];
	end

endmodule

// ==== verilog/tsp_top.sv ====
`timescale 1ns/1ps
`include "tsp_defines.svh"

module tsp_top (
	input  logic                          mpeg_clk,
	input  logic                          rst_n,
	input  logic                          wen,
	input  logic [`TSP_REG_ADDR_BITS-1:0] waddr,
	input  logic [31:0]                   wdata,
	input  logic                          ren,
	input  logic [`TSP_REG_ADDR_BITS-1:0] raddr,
	output logic [31:0]                   rdata,
	output logic                          rvalid,
	input  logic [7:0]                    mpeg_data,
	input  logic                          mpeg_valid,
	input  logic                          mpeg_sync
);
	import tsp_pkg::*;

	filter_cfg_t filter_cfg [`TSP_FILTER_NUM];
	logic        capture_done;
	logic [1:0]  capture_index;

	ts_mem_if cap_mem();
	ts_mem_if host_mem();
	ts_mem_if ram_mem(); // arbiter to ram

	tsp_host_regs u_host_regs (
		.mpeg_clk      (mpeg_clk),
		.rst_n         (rst_n),
		.wen           (wen),
		.ren           (ren),
		.waddr         (waddr),
		.raddr         (raddr),
		.wdata         (wdata),
		.rdata         (rdata),
		.rvalid        (rvalid),
		.capture_done  (capture_done),
		.capture_index (capture_index),
		.filter_cfg    (filter_cfg),
		.host_mem      (host_mem)
	);

	tsp_pid_capture u_pid_capture (
		.mpeg_clk      (mpeg_clk),
		.rst_n         (rst_n),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.filter_cfg    (filter_cfg),
		.cap_mem       (cap_mem),
		.capture_done  (capture_done),
		.capture_index (capture_index)
	);

	tsp_mem_arbiter u_mem_arbiter (
		.mpeg_clk (mpeg_clk),
		.rst_n    (rst_n),
		.cap_mem  (cap_mem),
		.host_mem (host_mem),
		.ram      (ram_mem)
	);

	tsp_packet_ram u_packet_ram (
		.mpeg_clk (mpeg_clk),
		.mem      (ram_mem)
	);

endmodule

// ==== test/tb_tsp_tasks.svh ====
task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
	@(posedge mpeg_clk);
	wen <= 1'b1;
	waddr <= addr;
	wdata <= data;
	@(posedge mpeg_clk);
	wen <= 1'b0;
endtask

task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
	int   n;
	logic data_rd;
	n = 0;
	data_rd = (addr >= 8'(`TSP_ADDR_TS_DATA_BASE)) &&
		(addr < 8'(`TSP_ADDR_TS_DATA_BASE + `TSP_PACK_WORDS));
	@(posedge mpeg_clk);
	ren <= 1'b1; // one cycle pulse
	raddr <= addr;
	@(posedge mpeg_clk);
	ren <= 1'b0;
	@(negedge mpeg_clk);
	if (!data_rd) // register or unmapped, answered next cycle
		check_flag($sformatf("rvalid 1 cycle after read of %0d", addr), 1'b1, rvalid);
	while (!rvalid) begin
		n++;
		if (n > 40)
			stop_on_timeout("rvalid never came back for a host read");
		@(negedge mpeg_clk);
	end
	if (data_rd && (n < 1 || n > 3)) begin
		$display("test %s: data read of address %0d took %0d cycles, allowed 2 to 4",
			cur_test, addr, n + 1);
		test_errs++;
		err_count++;
	end
	data = rdata;
endtask

task automatic select_filter(input int idx);
	host_write(`TSP_ADDR_INDEX, 32'(idx));
endtask

task automatic read_ready(input int idx, output logic flag);
	logic [31:0] v;
	select_filter(idx);
	host_read(`TSP_ADDR_READ_REQUEST, v);
	flag = v[0];
endtask

task automatic wait_ready(input int idx);
	int n;
	logic f;
	n = 0;
	read_ready(idx, f);
	while (!f) begin
		n++;
		if (n > 100)
			stop_on_timeout("ready flag never set after a matching packet");
		read_ready(idx, f);
	end
endtask

task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		$display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
		test_errs++;
		err_count++;
	end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	if (act !== exp) begin
		$display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
		test_errs++;
		err_count++;
	end
endtask

task automatic check_ready_flags();
	logic f;
	for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
		read_ready(i, f);
		check_flag($sformatf("ready %0d", i), model_ready[i], f);
	end
endtask

task automatic check_buffer(input int idx);
	logic [31:0] v;
	select_filter(idx);
	for (int w = 0; w < `TSP_PACK_WORDS; w++) begin
		host_read(8'(`TSP_ADDR_TS_DATA_BASE + w), v);
		check_word($sformatf("filter %0d word %0d", idx, w), model_buf[idx][w], v);
	end
endtask

// ==== test/tb_tsp.sv ====
`timescale 1ns/1ps
`include "tsp_defines.svh"

module tb_tsp;
	logic        mpeg_clk;
	logic        rst_n;
	logic        wen;
	logic        ren;
	logic [7:0]  waddr;
	logic [7:0]  raddr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        rvalid;
	logic [7:0]  mpeg_data;
	logic        mpeg_valid;
	logic        mpeg_sync;

	logic [31:0] seed;
	logic [12:0] pid_pool [6];
	logic [12:0] model_pid [`TSP_FILTER_NUM];
	logic        model_en [`TSP_FILTER_NUM];
	logic        model_armed [`TSP_FILTER_NUM];
	logic        model_ready [`TSP_FILTER_NUM];
	logic [31:0] model_buf [`TSP_FILTER_NUM][`TSP_PACK_WORDS];
	logic        stream_done;
	string       cur_test;
	int          test_errs;
	int          err_count;
	int          pass_count;
	int          fail_count;

	tsp_top u_tsp_top (
		.mpeg_clk   (mpeg_clk),
		.rst_n      (rst_n),
		.wen        (wen),
		.waddr      (waddr),
		.wdata      (wdata),
		.ren        (ren),
		.raddr      (raddr),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.mpeg_data  (mpeg_data),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync  (mpeg_sync)
	);

	`include "tb_tsp_tasks.svh"

	initial begin
		mpeg_clk = 1'b0;
		forever #10 mpeg_clk = ~mpeg_clk;
	end

	initial begin
		#2_000_000;
		$display("TIMEOUT: the run exceeded its overall time limit");
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("TIMEOUT in test %s: %s", cur_test, what);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			pass_count++;
			$display("test %s: ok", cur_test);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", cur_test, test_errs);
		end
	endtask

	task automatic set_filter(input int idx, input logic [12:0] pid, input logic en);
		logic [31:0] w;
		w = next_random(); // junk in unused bits
		w[12:0] = pid;
		w[16] = en;
		select_filter(idx);
		host_write(`TSP_ADDR_PID, w);
		model_pid[idx] = pid;
		model_en[idx] = en;
	endtask

	task automatic arm_filter(input int idx);
		select_filter(idx);
		host_write(`TSP_ADDR_READ_REQUEST, next_random());
		model_armed[idx] = 1'b1;
		model_ready[idx] = 1'b0;
	endtask

	task automatic send_packet(input logic [12:0] pid);
		logic [7:0]  pkt [`TSP_PACK_BYTES];
		logic [31:0] r;
		int          hit;
		r = next_random();
		pkt[0] = 8'h47;
		pkt[1] = {r[23:21], pid[12:8]};
		pkt[2] = pid[7:0];
		for (int k = 3; k < `TSP_PACK_BYTES; k++) begin
			r = next_random();
			pkt[k] = r[23:16];
		end
		hit = -1;
		for (int i = `TSP_FILTER_NUM - 1; i >= 0; i--) begin // lowest index wins
			if (model_en[i] && model_armed[i] && model_pid[i] == pid)
				hit = i;
		end
		if (hit >= 0) begin
			for (int w = 0; w < `TSP_PACK_WORDS; w++)
				model_buf[hit][w] = {pkt[4*w+3], pkt[4*w+2], pkt[4*w+1], pkt[4*w]};
			model_armed[hit] = 1'b0;
			model_ready[hit] = 1'b1;
		end
		for (int k = 0; k < `TSP_PACK_BYTES; k++) begin
			r = next_random();
			repeat (int'(r[31:30])) begin // idle gap
				@(posedge mpeg_clk);
				mpeg_valid <= 1'b0;
				mpeg_sync <= 1'b0;
			end
			@(posedge mpeg_clk);
			mpeg_valid <= 1'b1;
			mpeg_data <= pkt[k];
			mpeg_sync <= (k == 0);
		end
		@(posedge mpeg_clk);
		mpeg_valid <= 1'b0;
		mpeg_sync <= 1'b0;
		repeat (6) @(posedge mpeg_clk); // last word grant plus done pulse
	endtask

	task automatic poll_during_stream();
		logic [31:0] r;
		logic [31:0] v;
		logic        f;
		int          n;
		n = 0;
		while (!stream_done) begin
			n++;
			if (n > 2000)
				stop_on_timeout("stream did not finish while the host polled");
			r = next_random();
			read_ready(int'(r[31:30]), f);
			host_read(8'(`TSP_ADDR_TS_DATA_BASE + r[23:16] % `TSP_PACK_WORDS), v);
		end
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] r;
		logic        f;
		seed = 32'hc42e_44e0;
		rst_n = 1'b0;
		wen = 1'b0;
		ren = 1'b0;
		waddr = '0;
		raddr = '0;
		wdata = '0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		stream_done = 1'b0;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
			model_pid[i] = '0;
			model_en[i] = 1'b0;
			model_armed[i] = 1'b0;
			model_ready[i] = 1'b0;
		end
		for (int i = 0; i < 6; i++) begin
			r = next_random();
			pid_pool[i] = {r[28:19], 3'(i)}; // low bits keep the pool distinct
		end
		repeat (8) @(posedge mpeg_clk);
		rst_n <= 1'b1;
		@(posedge mpeg_clk);

		start_test("reset_state");
		check_ready_flags();
		for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
			select_filter(i);
			host_read(`TSP_ADDR_TS_DATA_BASE, v); // buffer word, only rvalid matters
			host_read(`TSP_ADDR_TS_DATA_BASE + `TSP_PACK_WORDS - 1, v);
			host_read(`TSP_ADDR_TS_DATA_BASE + `TSP_PACK_WORDS, v);
			check_word("word 47", 32'd0, v);
			host_read(8'd255, v);
			check_word("word 127", 32'd0, v);
			host_read(8'd77, v);
			check_word("unmapped", 32'd0, v);
		end
		finish_test();

		start_test("pid_readback");
		for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
			r = next_random();
			set_filter(i, r[28:16], r[5]);
		end
		for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
			select_filter(i);
			host_read(`TSP_ADDR_INDEX, v);
			check_word("index register", 32'(i), v);
			host_read(`TSP_ADDR_PID, v);
			check_word("pid register", {15'd0, model_en[i], 3'd0, model_pid[i]}, v);
		end
		finish_test();

		start_test("single_capture");
		set_filter(0, pid_pool[0], 1'b1);
		arm_filter(0);
		send_packet(pid_pool[4]);
		send_packet(pid_pool[5]);
		send_packet(pid_pool[0]);
		wait_ready(0);
		send_packet(pid_pool[0]); // filter no longer armed
		check_ready_flags();
		check_buffer(0);
		finish_test();

		start_test("disabled_or_unarmed");
		set_filter(1, pid_pool[4], 1'b0);
		arm_filter(1);
		set_filter(2, pid_pool[5], 1'b1);
		send_packet(pid_pool[4]);
		send_packet(pid_pool[5]);
		check_ready_flags();
		finish_test();

		start_test("multi_capture_contention");
		set_filter(0, pid_pool[1], 1'b1);
		set_filter(1, pid_pool[2], 1'b1);
		set_filter(2, pid_pool[1], 1'b1); // same pid as filter 0
		set_filter(3, pid_pool[3], 1'b1);
		for (int i = 0; i < `TSP_FILTER_NUM; i++)
			arm_filter(i);
		stream_done = 1'b0;
		fork
			begin
				send_packet(pid_pool[4]);
				send_packet(pid_pool[1]);
				send_packet(pid_pool[2]);
				send_packet(pid_pool[5]);
				send_packet(pid_pool[3]);
				send_packet(pid_pool[1]);
				send_packet(pid_pool[0]);
				stream_done = 1'b1;
			end
			poll_during_stream();
		join
		for (int i = 0; i < `TSP_FILTER_NUM; i++) begin
			if (model_ready[i])
				wait_ready(i);
		end
		check_ready_flags();
		for (int i = 0; i < `TSP_FILTER_NUM; i++)
			check_buffer(i);
		finish_test();

		start_test("rearm_replace");
		arm_filter(0);
		read_ready(0, f);
		check_flag("ready after re-arm", 1'b0, f);
		send_packet(model_pid[0]);
		wait_ready(0);
		check_ready_flags();
		check_buffer(0);
		finish_test();

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			pass_count, fail_count, err_count);
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+verilog
+incdir+test
verilog/tsp_pkg.sv
verilog/ts_mem_if.sv
verilog/tsp_host_regs.sv
verilog/tsp_pid_capture.sv
verilog/tsp_mem_arbiter.sv
verilog/tsp_packet_ram.sv
verilog/tsp_top.sv
test/tb_tsp.sv
